//--- bench/mmu_checker.sv
// protocol assertions on the page table memory port and the LSU response
// bound into mmu_top, failures raise $error and are counted for the testbench
`timescale 1ns/1ns

module mmu_checker (
    input logic clk_i,
    input logic rst_ni,
    input logic lsu_req_i,
    input logic lsu_valid_o,
    input logic mem_req_o,
    input logic mem_rvalid_i
);

    int unsigned fail_count = 0;

    // a memory request is held until its response arrives
    mem_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_o && !mem_rvalid_i |=> mem_req_o)
        else begin
            fail_count++;
            $error("mem_req_o dropped before mem_rvalid_i");
        end

    // a response needs a request in the cycle before
    valid_after_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
        lsu_valid_o |-> $past(lsu_req_i))
        else begin
            fail_count++;
            $error("lsu_valid_o without lsu_req_i in the cycle before");
        end

    quiet_in_reset: assert property (@(posedge clk_i)
        !rst_ni |-> !mem_req_o && !lsu_valid_o)
        else begin
            fail_count++;
            $error("mem_req_o or lsu_valid_o high during reset");
        end

endmodule

bind mmu_top mmu_checker mmu_checker_inst (.*);

//--- bench/mmu_tb.sv
// testbench for the data MMU: page table memory model, table of accesses and checks
// each row holds its request until lsu_valid_o, then address, cause and walk are compared
`timescale 1ns/1ns

module mmu_tb import mmu_pkg::*; ();

    localparam int unsigned RESET_CYCLES = 16;
    localparam int unsigned ROW_CYCLES   = 40;
    localparam int unsigned PT_WORDS     = 3072;
    localparam logic [PPNW-1:0] SATP_PPN = 22'h80;
    localparam logic [PLEN-1:0] PT_BASE  = 34'h8_0000;
    // pte flag bits
    localparam logic [7:0] F_V = 8'h01;
    localparam logic [7:0] F_R = 8'h02;
    localparam logic [7:0] F_W = 8'h04;
    localparam logic [7:0] F_U = 8'h10;
    localparam logic [7:0] F_A = 8'h40;
    localparam logic [7:0] F_D = 8'h80;

    typedef struct {
        logic [VLEN-1:0] vaddr;
        logic            is_store;
        priv_lvl_e       priv;
        logic            sum;
        logic            mxr;
        logic            en;
        logic            flush;
        logic [PLEN-1:0] exp_paddr;
        exc_cause_e      exp_cause;
        logic            exp_walk;
    } row_t;

    logic            clk_i;
    logic            rst_ni;
    logic            flush_i;
    logic            en_translation_i;
    priv_lvl_e       priv_lvl_i;
    logic            sum_i;
    logic            mxr_i;
    logic [PPNW-1:0] satp_ppn_i;
    logic            lsu_req_i;
    logic            lsu_is_store_i;
    logic [VLEN-1:0] lsu_vaddr_i;
    logic            lsu_valid_o;
    logic [PLEN-1:0] lsu_paddr_o;
    exception_t      lsu_exception_o;
    logic            mem_req_o;
    logic [PLEN-1:0] mem_addr_o;
    logic            mem_rvalid_i;
    logic            mem_err_i;
    pte_t            mem_rdata_i;

    row_t        rows[$];
    logic [31:0] pt_mem [PT_WORDS];
    logic [31:0] lfsr_q        = 32'd95419;
    logic        walk_seen     = 1'b0;
    int unsigned error_count   = 0;
    int unsigned rows_passed   = 0;
    int unsigned rows_failed   = 0;
    int unsigned cycle_count   = 0;
    int unsigned timeout_limit = 100000;

    mmu_top #(
        .TLB_ENTRIES ( 4 )
    ) mmu_top_inst (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count > timeout_limit) begin
            $display("timeout: no response from the MMU after %0d cycles", cycle_count);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // ------------------------------
    // page table memory
    // ------------------------------
    // Fibonacci LFSR, taps 32 22 2 1
    function logic lfsr_bit();
        logic fb;
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function logic in_table(input logic [PLEN-1:0] addr);
        return (addr >= PT_BASE) && (addr < PT_BASE + PLEN'(PT_WORDS * 4));
    endfunction

    task set_pte(input logic [PLEN-1:0] addr, input logic [PPNW-1:0] ppn,
                 input logic [7:0] flags);
        pt_mem[(addr - PT_BASE) >> 2] = {ppn, 2'b00, flags};
    endtask

    // addresses outside the table answer with an access error
    initial begin
        logic [PLEN-1:0] addr;
        int unsigned     delay;
        forever begin
            @(negedge clk_i);
            if (mem_req_o) begin
                walk_seen = 1'b1;
                addr      = mem_addr_o;
                delay     = 1 + {lfsr_bit(), lfsr_bit()};
                repeat (delay) @(posedge clk_i);
                #5;
                mem_rvalid_i = 1'b1;
                mem_err_i    = !in_table(addr);
                mem_rdata_i  = in_table(addr) ? pte_t'(pt_mem[(addr - PT_BASE) >> 2]) : '0;
                @(posedge clk_i);
                #5;
                mem_rvalid_i = 1'b0;
                mem_err_i    = 1'b0;
                mem_rdata_i  = '0;
            end
        end
    end

    task build_page_table();
        foreach (pt_mem[i]) pt_mem[i] = '0;
        // root table, vpn1 1 points to the level-0 table, 2 is a superpage
        set_pte(34'h8_0004, 22'h81, F_V);
        set_pte(34'h8_0008, 22'h0ABC00, F_V | F_R | F_W | F_A | F_D);
        set_pte(34'h8_000C, 22'h90, F_V);
        // level-0 table, entry 3 stays invalid
        set_pte(34'h8_1000, 22'h12345, F_V | F_R | F_W | F_A | F_D);
        set_pte(34'h8_1004, 22'h23456, F_V | F_R | F_A);
        set_pte(34'h8_1008, 22'h34567, F_V | F_R | F_W | F_U | F_A | F_D);
        set_pte(34'h8_1010, 22'h45678, F_V | F_R | F_W | F_A);
    endtask

    // ------------------------------
    // stimulus table
    // ------------------------------
    task add_row(input logic [VLEN-1:0] vaddr, input logic st, input priv_lvl_e priv,
                 input logic sum, input logic mxr, input logic en, input logic flush,
                 input logic [PLEN-1:0] paddr, input exc_cause_e cause, input logic walk);
        row_t r;
        r = '{vaddr, st, priv, sum, mxr, en, flush, paddr, cause, walk};
        rows.push_back(r);
    endtask

    task build_rows();
        // vaddr, store, priv, sum, mxr, en, flush, paddr, cause, walk
        add_row(32'h1234_5678, 0, PRIV_S, 0, 0, 0, 0, 34'h0_1234_5678, EXC_NONE, 0);
        add_row(32'hFFFF_FFFC, 1, PRIV_S, 0, 0, 0, 0, 34'h0_FFFF_FFFC, EXC_NONE, 0);
        add_row(32'h0040_0ABC, 0, PRIV_S, 0, 0, 1, 0, 34'h1_2345_ABC, EXC_NONE, 1);
        add_row(32'h0040_0010, 1, PRIV_S, 0, 0, 1, 0, 34'h1_2345_010, EXC_NONE, 0);
        add_row(32'h0081_2345, 0, PRIV_S, 0, 0, 1, 0, 34'h0_ABC1_2345, EXC_NONE, 1);
        add_row(32'h0040_1008, 1, PRIV_S, 0, 0, 1, 0, '0, STORE_PAGE_FAULT, 1);
        add_row(32'h0040_1008, 0, PRIV_S, 0, 0, 1, 0, 34'h2_3456_008, EXC_NONE, 0);
        add_row(32'h0040_2100, 0, PRIV_S, 0, 0, 1, 0, '0, LOAD_PAGE_FAULT, 1);
        add_row(32'h0040_2100, 0, PRIV_S, 1, 0, 1, 0, 34'h3_4567_100, EXC_NONE, 0);
        add_row(32'h0040_2200, 1, PRIV_U, 0, 0, 1, 0, 34'h3_4567_200, EXC_NONE, 0);
        add_row(32'h0040_0000, 0, PRIV_U, 0, 0, 1, 0, '0, LOAD_PAGE_FAULT, 0);
        add_row(32'h0040_4000, 1, PRIV_S, 0, 0, 1, 0, '0, STORE_PAGE_FAULT, 1);
        add_row(32'h0040_3000, 0, PRIV_S, 0, 0, 1, 0, '0, LOAD_PAGE_FAULT, 1);
        add_row(32'h0000_1000, 1, PRIV_S, 0, 0, 1, 0, '0, STORE_PAGE_FAULT, 1);
        add_row(32'h00C0_0000, 0, PRIV_S, 0, 0, 1, 0, '0, LD_ACCESS_FAULT, 1);
        add_row(32'h00C0_1000, 1, PRIV_S, 0, 0, 1, 0, '0, ST_ACCESS_FAULT, 1);
        // page 0x00401 is still cached, so only the flush can force a new walk
        add_row(32'h0040_1ABC, 0, PRIV_S, 0, 0, 1, 0, 34'h2_3456_ABC, EXC_NONE, 0);
        add_row(32'h0040_1ABC, 0, PRIV_S, 0, 0, 1, 1, 34'h2_3456_ABC, EXC_NONE, 1);
    endtask

    // ------------------------------
    // compare tasks
    // ------------------------------
    task check_paddr(input int row, input logic [PLEN-1:0] got, input logic [PLEN-1:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t: row %0d paddr %h, expected %h", $time, row, got, exp);
            error_count++;
        end
    endtask

    // tval only matters when a fault is reported
    task check_exc(input int row, input exception_t got, input exception_t exp);
        if (got.valid !== exp.valid || got.cause !== exp.cause
                || (exp.valid && got.tval !== exp.tval)) begin
            $display("FAIL %0t: row %0d cause %0d tval %h valid %0b, expected %0d %h %0b",
                     $time, row, got.cause, got.tval, got.valid,
                     exp.cause, exp.tval, exp.valid);
            error_count++;
        end
    endtask

    task check_walk(input int row, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %0t: row %0d walk seen %0b, expected %0b", $time, row, got, exp);
            error_count++;
        end
    endtask

    task run_row(input int idx);
        row_t            r;
        exception_t      exp_exc;
        logic [PLEN-1:0] paddr;
        exception_t      exc;
        int unsigned     errors_before;
        r             = rows[idx];
        errors_before = error_count;
        @(posedge clk_i);
        #5;
        if (r.flush) begin
            flush_i = 1'b1;
            @(posedge clk_i);
            #5;
            flush_i = 1'b0;
        end
        en_translation_i = r.en;
        priv_lvl_i       = r.priv;
        sum_i            = r.sum;
        mxr_i            = r.mxr;
        lsu_vaddr_i      = r.vaddr;
        lsu_is_store_i   = r.is_store;
        walk_seen        = 1'b0;
        lsu_req_i        = 1'b1;
        @(negedge clk_i);
        while (!lsu_valid_o) @(negedge clk_i);
        paddr = lsu_paddr_o;
        exc   = lsu_exception_o;
        @(posedge clk_i);
        #5;
        lsu_req_i = 1'b0;
        exp_exc.cause = r.exp_cause;
        exp_exc.valid = (r.exp_cause != EXC_NONE);
        exp_exc.tval  = exp_exc.valid ? r.vaddr : '0;
        check_exc(idx, exc, exp_exc);
        if (!exp_exc.valid) begin
            check_paddr(idx, paddr, r.exp_paddr);
        end
        check_walk(idx, walk_seen, r.exp_walk);
        if (error_count == errors_before) begin
            rows_passed++;
            $display("row %0d vaddr %h: ok", idx, r.vaddr);
        end else begin
            rows_failed++;
            $display("row %0d vaddr %h: mismatch", idx, r.vaddr);
        end
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        rst_ni           = 1'b0;
        flush_i          = 1'b0;
        en_translation_i = 1'b0;
        priv_lvl_i       = PRIV_S;
        sum_i            = 1'b0;
        mxr_i            = 1'b0;
        satp_ppn_i       = SATP_PPN;
        lsu_req_i        = 1'b0;
        lsu_is_store_i   = 1'b0;
        lsu_vaddr_i      = '0;
        mem_rvalid_i     = 1'b0;
        mem_err_i        = 1'b0;
        mem_rdata_i      = '0;
        build_page_table();
        build_rows();
        timeout_limit = rows.size() * ROW_CYCLES + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #5;
        rst_ni = 1'b1;
        for (int i = 0; i < rows.size(); i++) begin
            run_row(i);
        end
        $display("rows passed %0d, rows failed %0d, assertion failures %0d",
                 rows_passed, rows_failed, mmu_top_inst.mmu_checker_inst.fail_count);
        if (rows_failed == 0 && mmu_top_inst.mmu_checker_inst.fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- common/mmu_pkg.sv
// shared widths, page table entry layout and exception record of the Sv32 data MMU
// compiled before every other MMU file and imported where needed
package mmu_pkg;

    // ----------------------------
    // address widths
    // ----------------------------
    localparam int unsigned VLEN          = 32;
    localparam int unsigned PLEN          = 34;
    localparam int unsigned PPNW          = 22;
    localparam int unsigned VPNW          = 10;
    localparam int unsigned PAGE_OFFSET_W = 12;

    // Sv32 page table entry, v in bit 0
    typedef struct packed {
        logic [PPNW-1:0] ppn;
        logic [1:0]      rsw;
        logic            d;
        logic            a;
        logic            g;
        logic            u;
        logic            x;
        logic            w;
        logic            r;
        logic            v;
    } pte_t;

    // ----------------------------
    // exceptions
    // ----------------------------
    typedef enum logic [3:0] {
        EXC_NONE         = 4'd0,
        LD_ACCESS_FAULT  = 4'd5,
        ST_ACCESS_FAULT  = 4'd7,
        LOAD_PAGE_FAULT  = 4'd13,
        STORE_PAGE_FAULT = 4'd15
    } exc_cause_e;

    // tval carries the faulting virtual address
    typedef struct packed {
        exc_cause_e      cause;
        logic [VLEN-1:0] tval;
        logic            valid;
    } exception_t;

    // machine mode never translates
    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1
    } priv_lvl_e;

    // ----------------------------
    // page table walker
    // ----------------------------
    typedef enum logic [2:0] {
        IDLE,
        WAIT_L1,
        WAIT_L0,
        DONE,
        ERROR
    } ptw_state_e;

    typedef enum logic [1:0] {
        PTW_OK,
        PTW_PAGE_FAULT,
        PTW_ACCESS_FAULT
    } ptw_err_e;

endpackage

//--- common/tlb_update_if.sv
// carries the leaf of a finished page table walk into the data TLB
// the walker drives it, the TLB writes the entry on the valid strobe
`timescale 1ns/1ns

interface tlb_update_if import mmu_pkg::*; ();

    // one-cycle fill strobe
    logic              valid;
    // full virtual page number of the walked address
    logic [2*VPNW-1:0] vpn;
    pte_t              pte;
    // leaf found at level 1
    logic              is_super;

    modport walker (
        output valid,
        output vpn,
        output pte,
        output is_super
    );

    modport tlb (
        input valid,
        input vpn,
        input pte,
        input is_super
    );

endinterface

//--- files.f
common/mmu_pkg.sv
common/tlb_update_if.sv
tlb/dtlb.sv
ptw/ptw_fsm.sv
hdl/lsu_xlate_stage.sv
hdl/mmu_top.sv
bench/mmu_checker.sv
bench/mmu_tb.sv

//--- hdl/lsu_xlate_stage.sv
// registered LSU translation stage: physical address, permission check and response
// answers one cycle after a TLB hit, or in the cycle the walker reports an error
`timescale 1ns/1ns

module lsu_xlate_stage import mmu_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            en_translation_i,
    input  priv_lvl_e       priv_lvl_i,
    input  logic            sum_i,
    input  logic            mxr_i,
    input  logic            lsu_req_i,
    input  logic            lsu_is_store_i,
    input  logic [VLEN-1:0] lsu_vaddr_i,
    input  logic            tlb_hit_i,
    input  pte_t            tlb_pte_i,
    input  logic            tlb_is_super_i,
    input  ptw_err_e        walk_err_i,
    input  logic [VLEN-1:0] walk_vaddr_i,
    output logic            lsu_valid_o,
    output logic [PLEN-1:0] lsu_paddr_o,
    output exception_t      lsu_exception_o
);

    logic            req_n;
    logic            req_q;
    logic            hit_q;
    logic            is_store_q;
    logic [VLEN-1:0] vaddr_q;
    pte_t            pte_q;
    logic            super_q;
    logic            priv_err;
    logic            perm_err;

    // the request is still held in the cycle it is answered, so it is not taken twice
    assign req_n = lsu_req_i && !lsu_valid_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_q <= 1'b0;
            hit_q <= 1'b0;
        end else begin
            req_q <= req_n;
            hit_q <= tlb_hit_i;
        end
    end

    always_ff @(posedge clk_i) begin
        is_store_q <= lsu_is_store_i;
        vaddr_q    <= lsu_vaddr_i;
        pte_q      <= tlb_pte_i;
        super_q    <= tlb_is_super_i;
    end

    // ----------------------------
    // permission check
    // ----------------------------
    always_comb begin
        priv_err = ((priv_lvl_i == PRIV_U) && !pte_q.u)
                || ((priv_lvl_i == PRIV_S) && pte_q.u && !sum_i);
        if (is_store_q) begin
            perm_err = priv_err || !pte_q.w || !pte_q.d;
        end else begin
            // mxr makes executable pages readable
            perm_err = priv_err || !(pte_q.r || (pte_q.x && mxr_i));
        end
    end

    // ----------------------------
    // response
    // ----------------------------
    always_comb begin
        lsu_valid_o           = 1'b0;
        lsu_paddr_o           = {{(PLEN-VLEN){1'b0}}, vaddr_q};
        lsu_exception_o.cause = EXC_NONE;
        lsu_exception_o.tval  = '0;
        lsu_exception_o.valid = 1'b0;
        if (!en_translation_i) begin
            lsu_valid_o = req_q;
        end else begin
            lsu_paddr_o = {pte_q.ppn, vaddr_q[PAGE_OFFSET_W-1:0]};
            // superpage keeps the lower VPN of the vaddr
            if (super_q) begin
                lsu_paddr_o[PAGE_OFFSET_W +: VPNW] = vaddr_q[PAGE_OFFSET_W +: VPNW];
            end
            if (req_q && hit_q) begin
                lsu_valid_o = 1'b1;
                if (perm_err) begin
                    lsu_exception_o.cause = is_store_q ? STORE_PAGE_FAULT : LOAD_PAGE_FAULT;
                    lsu_exception_o.tval  = vaddr_q;
                    lsu_exception_o.valid = 1'b1;
                end
            end else if (walk_err_i != PTW_OK) begin
                lsu_valid_o           = 1'b1;
                lsu_exception_o.tval  = walk_vaddr_i;
                lsu_exception_o.valid = 1'b1;
                if (walk_err_i == PTW_ACCESS_FAULT) begin
                    lsu_exception_o.cause = is_store_q ? ST_ACCESS_FAULT : LD_ACCESS_FAULT;
                end else begin
                    lsu_exception_o.cause = is_store_q ? STORE_PAGE_FAULT : LOAD_PAGE_FAULT;
                end
            end
        end
    end

endmodule

//--- hdl/mmu_top.sv
// data-side Sv32 MMU for the LSU: TLB lookup, page table walk and permission check
// translated responses arrive one cycle after the hit, faults end a failed walk
`timescale 1ns/1ns

module mmu_top import mmu_pkg::*; #(
    parameter int unsigned TLB_ENTRIES = 4
) (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             flush_i,
    input  logic             en_translation_i,
    input  priv_lvl_e        priv_lvl_i,
    input  logic             sum_i,
    input  logic             mxr_i,
    input  logic [PPNW-1:0]  satp_ppn_i,
    // LSU side
    input  logic             lsu_req_i,
    input  logic             lsu_is_store_i,
    input  logic [VLEN-1:0]  lsu_vaddr_i,
    output logic             lsu_valid_o,
    output logic [PLEN-1:0]  lsu_paddr_o,
    output exception_t       lsu_exception_o,
    // page table memory
    output logic             mem_req_o,
    output logic [PLEN-1:0]  mem_addr_o,
    input  logic             mem_rvalid_i,
    input  logic             mem_err_i,
    input  pte_t             mem_rdata_i
);

    logic            tlb_hit;
    pte_t            tlb_pte;
    logic            tlb_is_super;
    ptw_err_e        walk_err;
    logic [VLEN-1:0] walk_vaddr;

    tlb_update_if tlb_upd ();

    dtlb #(
        .TLB_ENTRIES   ( TLB_ENTRIES  )
    ) dtlb_inst (
        .clk_i         ( clk_i        ),
        .rst_ni        ( rst_ni       ),
        .flush_i       ( flush_i      ),
        .lu_vaddr_i    ( lsu_vaddr_i  ),
        .lu_hit_o      ( tlb_hit      ),
        .lu_pte_o      ( tlb_pte      ),
        .lu_is_super_o ( tlb_is_super ),
        .upd           ( tlb_upd.tlb  )
    );

    ptw_fsm ptw_fsm_inst (
        .clk_i            ( clk_i            ),
        .rst_ni           ( rst_ni           ),
        .en_translation_i ( en_translation_i ),
        .lsu_req_i        ( lsu_req_i        ),
        .lsu_vaddr_i      ( lsu_vaddr_i      ),
        .tlb_hit_i        ( tlb_hit          ),
        .satp_ppn_i       ( satp_ppn_i       ),
        .mem_req_o        ( mem_req_o        ),
        .mem_addr_o       ( mem_addr_o       ),
        .mem_rvalid_i     ( mem_rvalid_i     ),
        .mem_err_i        ( mem_err_i        ),
        .mem_rdata_i      ( mem_rdata_i      ),
        .walk_err_o       ( walk_err         ),
        .walk_vaddr_o     ( walk_vaddr       ),
        .upd              ( tlb_upd.walker   )
    );

    lsu_xlate_stage lsu_xlate_stage_inst (
        .clk_i            ( clk_i            ),
        .rst_ni           ( rst_ni           ),
        .en_translation_i ( en_translation_i ),
        .priv_lvl_i       ( priv_lvl_i       ),
        .sum_i            ( sum_i            ),
        .mxr_i            ( mxr_i            ),
        .lsu_req_i        ( lsu_req_i        ),
        .lsu_is_store_i   ( lsu_is_store_i   ),
        .lsu_vaddr_i      ( lsu_vaddr_i      ),
        .tlb_hit_i        ( tlb_hit          ),
        .tlb_pte_i        ( tlb_pte          ),
        .tlb_is_super_i   ( tlb_is_super     ),
        .walk_err_i       ( walk_err         ),
        .walk_vaddr_i     ( walk_vaddr       ),
        .lsu_valid_o      ( lsu_valid_o      ),
        .lsu_paddr_o      ( lsu_paddr_o      ),
        .lsu_exception_o  ( lsu_exception_o  )
    );

endmodule

//--- ptw/ptw_fsm.sv
// two-level Sv32 page table walker, started by a translated LSU request that misses
// ends in DONE with a TLB fill or in ERROR with a page or access fault
`timescale 1ns/1ns

module ptw_fsm import mmu_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            en_translation_i,
    input  logic            lsu_req_i,
    input  logic [VLEN-1:0] lsu_vaddr_i,
    input  logic            tlb_hit_i,
    input  logic [PPNW-1:0] satp_ppn_i,
    // page table memory
    output logic            mem_req_o,
    output logic [PLEN-1:0] mem_addr_o,
    input  logic            mem_rvalid_i,
    input  logic            mem_err_i,
    input  pte_t            mem_rdata_i,
    // result towards the translate stage
    output ptw_err_e        walk_err_o,
    output logic [VLEN-1:0] walk_vaddr_o,
    tlb_update_if.walker    upd
);

    ptw_state_e      state_q;
    ptw_state_e      state_n;
    ptw_err_e        err_q;
    ptw_err_e        err_n;
    logic            req_q;
    logic            req_n;
    logic [VLEN-1:0] vaddr_q;
    pte_t            pte_q;
    logic            super_q;
    logic            start;
    logic            rsp;
    logic            pte_bad;
    logic            pte_leaf;
    logic            leaf_bad;

    assign start = en_translation_i && lsu_req_i && !tlb_hit_i;
    assign rsp   = mem_rvalid_i && req_q;

    // decode of the entry coming back from memory
    assign pte_bad  = !mem_rdata_i.v || (mem_rdata_i.w && !mem_rdata_i.r);
    assign pte_leaf = mem_rdata_i.r || mem_rdata_i.x;
    // misaligned superpage or accessed bit clear
    assign leaf_bad = ((state_q == WAIT_L1) && (mem_rdata_i.ppn[VPNW-1:0] != '0))
                   || !mem_rdata_i.a;

    // ----------------------------
    // next state
    // ----------------------------
    always_comb begin
        state_n = state_q;
        err_n   = err_q;
        req_n   = req_q;
        case (state_q)
            IDLE: begin
                if (start) begin
                    state_n = WAIT_L1;
                    err_n   = PTW_OK;
                    req_n   = 1'b1;
                end
            end
            WAIT_L1, WAIT_L0: begin
                if (!req_q) begin
                    // request for the level-0 entry goes out one cycle after the pointer
                    req_n = 1'b1;
                end else if (rsp) begin
                    req_n = 1'b0;
                    if (mem_err_i) begin
                        state_n = ERROR;
                        err_n   = PTW_ACCESS_FAULT;
                    end else if (pte_bad) begin
                        state_n = ERROR;
                        err_n   = PTW_PAGE_FAULT;
                    end else if (pte_leaf) begin
                        state_n = leaf_bad ? ERROR : DONE;
                        err_n   = leaf_bad ? PTW_PAGE_FAULT : PTW_OK;
                    end else if (state_q == WAIT_L1) begin
                        state_n = WAIT_L0;
                    end else begin
                        // pointer at the last level
                        state_n = ERROR;
                        err_n   = PTW_PAGE_FAULT;
                    end
                end
            end
            DONE, ERROR: begin
                state_n = IDLE;
            end
            default: begin
                state_n = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            err_q   <= PTW_OK;
            req_q   <= 1'b0;
        end else begin
            state_q <= state_n;
            err_q   <= err_n;
            req_q   <= req_n;
        end
    end

    // walked address and last entry read, pte_q.ppn also points to the level-0 table
    always_ff @(posedge clk_i) begin
        if ((state_q == IDLE) && start) begin
            vaddr_q <= lsu_vaddr_i;
        end
        if (rsp) begin
            pte_q   <= mem_rdata_i;
            super_q <= (state_q == WAIT_L1);
        end
    end

    // ----------------------------
    // outputs
    // ----------------------------
    assign mem_req_o  = req_q;
    assign mem_addr_o = (state_q == WAIT_L0)
                      ? {pte_q.ppn, vaddr_q[PAGE_OFFSET_W +: VPNW], 2'b00}
                      : {satp_ppn_i, vaddr_q[VLEN-1 -: VPNW], 2'b00};

    assign walk_err_o   = (state_q == ERROR) ? err_q : PTW_OK;
    assign walk_vaddr_o = vaddr_q;

    assign upd.valid    = (state_q == DONE);
    assign upd.vpn      = vaddr_q[VLEN-1:PAGE_OFFSET_W];
    assign upd.pte      = pte_q;
    assign upd.is_super = super_q;

endmodule

//--- tlb/dtlb.sv
// fully associative data TLB with same-cycle lookup and round-robin refill
// filled by the page table walker, emptied as a whole by flush_i
`timescale 1ns/1ns

module dtlb import mmu_pkg::*; #(
    parameter int unsigned TLB_ENTRIES = 4
) (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            flush_i,
    input  logic [VLEN-1:0] lu_vaddr_i,
    output logic            lu_hit_o,
    output pte_t            lu_pte_o,
    output logic            lu_is_super_o,
    tlb_update_if.tlb       upd
);

    localparam int unsigned PTR_W = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1;

    logic [TLB_ENTRIES-1:0] valid_q;
    logic [TLB_ENTRIES-1:0] super_q;
    logic [2*VPNW-1:0]      vpn_q [TLB_ENTRIES];
    pte_t                   pte_q [TLB_ENTRIES];
    logic [PTR_W-1:0]       ptr_q;
    logic [TLB_ENTRIES-1:0] match;
    logic [VPNW-1:0]        lu_vpn1;
    logic [VPNW-1:0]        lu_vpn0;

    assign lu_vpn1 = lu_vaddr_i[VLEN-1 -: VPNW];
    assign lu_vpn0 = lu_vaddr_i[PAGE_OFFSET_W +: VPNW];

    // ----------------------------
    // lookup
    // ----------------------------
    // a superpage entry ignores the lower VPN, lowest matching entry wins
    always_comb begin
        lu_hit_o      = 1'b0;
        lu_pte_o      = '0;
        lu_is_super_o = 1'b0;
        for (int unsigned i = 0; i < TLB_ENTRIES; i++) begin
            match[i] = valid_q[i]
                    && (vpn_q[i][2*VPNW-1:VPNW] == lu_vpn1)
                    && (super_q[i] || (vpn_q[i][VPNW-1:0] == lu_vpn0));
            if (match[i] && !lu_hit_o) begin
                lu_hit_o      = 1'b1;
                lu_pte_o      = pte_q[i];
                lu_is_super_o = super_q[i];
            end
        end
    end

    // ----------------------------
    // fill and flush
    // ----------------------------
    // flush wins over a fill arriving in the same cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            ptr_q   <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else if (upd.valid) begin
            valid_q[ptr_q] <= 1'b1;
            if (ptr_q == PTR_W'(TLB_ENTRIES - 1)) begin
                ptr_q <= '0;
            end else begin
                ptr_q <= ptr_q + 1'b1;
            end
        end
    end

    // entry contents, qualified by valid_q
    always_ff @(posedge clk_i) begin
        if (upd.valid && !flush_i) begin
            vpn_q[ptr_q]   <= upd.vpn;
            pte_q[ptr_q]   <= upd.pte;
            super_q[ptr_q] <= upd.is_super;
        end
    end

endmodule
